//--- flist.f
hdl/ir_pkg.sv
hdl/ir_pulse_if.sv
hdl/ir_pulse_timer.sv
hdl/nec_frame_decoder.sv
hdl/ir_code_queue.sv
hdl/ir_rx_top.sv
+incdir+tb
tb/ir_rx_tb.sv

//--- hdl/ir_code_queue.sv
`timescale 1ns/1ps

module ir_code_queue (
    input  logic              clk_1us,
    input  logic              ir,
    input  logic              push,
    input  ir_pkg::ir_code_t  push_code,
    input  logic              credit_return,
    output logic              code_valid,
    output ir_pkg::ir_code_t  code,
    output logic              overrun
);

    ir_pkg::ir_code_t mem [ir_pkg::QUEUE_DEPTH];

    logic [ir_pkg::QUEUE_PTR_W-1:0] wr_ptr;
    logic [ir_pkg::QUEUE_PTR_W-1:0] rd_ptr;
    logic [ir_pkg::QUEUE_CNT_W-1:0] count;
    logic [ir_pkg::CREDIT_W-1:0]    credits;

    logic empty;
    logic full;
    logic do_write;
    logic do_pop;
    logic credit_max;

    assign empty      = count == '0;
    assign full       = count == ir_pkg::QUEUE_CNT_W'(ir_pkg::QUEUE_DEPTH);
    assign credit_max = credits == ir_pkg::CREDIT_W'(ir_pkg::CONSUMER_CREDITS);
    assign do_write   = push && !full;

    // head entry leaves as soon as a credit covers it.
    assign code_valid = !empty && (credits != '0);
    assign do_pop     = code_valid;
    assign code       = mem[rd_ptr];

    always_ff @(posedge clk_1us) begin
        if (do_write) begin
            mem[wr_ptr] <= push_code;
        end
    end

    // ******************************
    // pointers and occupancy
    // ******************************

    always_ff @(posedge clk_1us or negedge ir) begin
        if (!ir) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == ir_pkg::QUEUE_PTR_W'(ir_pkg::QUEUE_DEPTH - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ir_pkg::QUEUE_PTR_W'(ir_pkg::QUEUE_DEPTH - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ******************************
    // credits and overrun
    // ******************************

    always_ff @(posedge clk_1us or negedge ir) begin
        if (!ir) begin
            credits <= ir_pkg::CREDIT_W'(ir_pkg::CONSUMER_CREDITS);
            overrun <= 1'b0;
        end else begin
            if (do_pop && !credit_return) begin
                credits <= credits - 1'b1;
            end else if (credit_return && !do_pop && !credit_max) begin
                credits <= credits + 1'b1;
            end
            // sticky until reset.
            if (push && full) begin
                overrun <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/ir_pkg.sv
package ir_pkg;

    // ******************************
    // field and width types
    // ******************************

    // segment width in 1 us ticks, saturating.
    typedef logic [15:0] width_t;

    typedef logic [15:0] ir_addr_t;
    typedef logic [7:0]  ir_cmd_t;

    // repeat flag, address, command from the top bit down.
    typedef logic [24:0] ir_code_t;

    // ******************************
    // timing windows in ticks
    // ******************************

    localparam width_t LEADER_MARK_MIN  = 16'd8000;
    localparam width_t LEADER_MARK_MAX  = 16'd10000;
    localparam width_t LEADER_SPACE_MIN = 16'd4000;
    localparam width_t LEADER_SPACE_MAX = 16'd5000;
    localparam width_t REPEAT_SPACE_MIN = 16'd1900;
    localparam width_t REPEAT_SPACE_MAX = 16'd2600;
    localparam width_t BIT_MARK_MIN     = 16'd400;
    localparam width_t BIT_MARK_MAX     = 16'd750;
    localparam width_t ZERO_SPACE_MIN   = 16'd400;
    localparam width_t ZERO_SPACE_MAX   = 16'd750;
    localparam width_t ONE_SPACE_MIN    = 16'd1450;
    localparam width_t ONE_SPACE_MAX    = 16'd1950;

    // ******************************
    // frame and queue sizes
    // ******************************

    localparam int FRAME_BITS       = 32;
    localparam int QUEUE_DEPTH      = 4;
    localparam int CONSUMER_CREDITS = 2;

    localparam int BIT_CNT_W   = $clog2(FRAME_BITS + 1);
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);
    localparam int CREDIT_W    = $clog2(CONSUMER_CREDITS + 1);

    typedef enum logic [2:0] {
        idle,
        leader_space,
        bit_mark,
        bit_space,
        repeat_mark,
        stop_mark
    } dec_state_e;

endpackage

//--- hdl/ir_pulse_if.sv
`timescale 1ns/1ps

interface ir_pulse_if;

    // one pulse per finished segment.
    logic valid;

    // line level of the segment, 0 is a mark.
    logic level;

    ir_pkg::width_t width;
    logic saturated;

    modport timer (
        output valid,
        output level,
        output width,
        output saturated
    );

    modport decoder (
        input valid,
        input level,
        input width,
        input saturated
    );

endinterface

//--- hdl/ir_pulse_timer.sv
`timescale 1ns/1ps

module ir_pulse_timer (
    input  logic       clk_1us,
    input  logic       ir,
    input  logic       ir_rx,
    ir_pulse_if.timer  pulse
);

    // ******************************
    // synchronizer and edge detect
    // ******************************

    logic [1:0]     sync;
    logic           line_s;
    logic           line_d;
    logic           line_edge;
    ir_pkg::width_t width_cnt;
    logic           cnt_full;

    assign line_s    = sync[1];
    assign line_edge = line_s != line_d;
    assign cnt_full  = width_cnt == '1;

    // line idles high, so the flops start there.
    always_ff @(posedge clk_1us or negedge ir) begin
        if (!ir) begin
            sync   <= 2'b11;
            line_d <= 1'b1;
        end else begin
            sync   <= {sync[0], ir_rx};
            line_d <= line_s;
        end
    end

    // ******************************
    // width counter
    // ******************************

    // the edge cycle is the first tick of the next segment.
    always_ff @(posedge clk_1us or negedge ir) begin
        if (!ir) begin
            width_cnt <= '0;
        end else if (line_edge) begin
            width_cnt <= ir_pkg::width_t'(1);
        end else if (!cnt_full) begin
            width_cnt <= width_cnt + 1'b1;
        end
    end

    // ******************************
    // event register
    // ******************************

    always_ff @(posedge clk_1us or negedge ir) begin
        if (!ir) begin
            pulse.valid <= 1'b0;
        end else begin
            pulse.valid <= line_edge;
        end
    end

    // level before the edge is the level of the segment that ended.
    always_ff @(posedge clk_1us) begin
        if (line_edge) begin
            pulse.level     <= line_d;
            pulse.width     <= width_cnt;
            pulse.saturated <= cnt_full;
        end
    end

endmodule

//--- hdl/ir_rx_top.sv
`timescale 1ns/1ps

module ir_rx_top (
    input  logic              clk_1us,
    input  logic              ir,
    input  logic              ir_rx,
    input  logic              credit_return,
    output logic              code_valid,
    output ir_pkg::ir_code_t  code,
    output logic              overrun
);

    logic             push;
    ir_pkg::ir_code_t push_code;

    // measured segments, timer to decoder.
    ir_pulse_if pulse_bus ();

    ir_pulse_timer u_pulse_timer (
        .clk_1us (clk_1us),
        .ir      (ir),
        .ir_rx   (ir_rx),
        .pulse   (pulse_bus.timer)
    );

    nec_frame_decoder u_frame_decoder (
        .clk_1us   (clk_1us),
        .ir        (ir),
        .pulse     (pulse_bus.decoder),
        .push      (push),
        .push_code (push_code)
    );

    ir_code_queue u_code_queue (
        .clk_1us       (clk_1us),
        .ir            (ir),
        .push          (push),
        .push_code     (push_code),
        .credit_return (credit_return),
        .code_valid    (code_valid),
        .code          (code),
        .overrun       (overrun)
    );

endmodule

//--- hdl/nec_frame_decoder.sv
`timescale 1ns/1ps

module nec_frame_decoder (
    input  logic              clk_1us,
    input  logic              ir,
    ir_pulse_if.decoder       pulse,
    output logic              push,
    output ir_pkg::ir_code_t  push_code
);

    ir_pkg::dec_state_e state;

    logic [ir_pkg::BIT_CNT_W-1:0]  bit_cnt;
    logic [ir_pkg::FRAME_BITS-1:0] shift_reg;
    logic [ir_pkg::FRAME_BITS-1:0] shift_next;

    logic have_last;
    ir_pkg::ir_addr_t last_addr;
    ir_pkg::ir_cmd_t  last_cmd;

    logic is_mark;
    logic is_space;
    logic leader_mark;
    logic bit_mark_ok;
    logic zero_space;
    logic one_space;
    logic leader_gap;
    logic repeat_gap;
    logic bit_taken;
    logic last_bit;
    logic inverse_ok;
    logic frame_ok;
    logic repeat_hit;

    function automatic logic in_win(
        input ir_pkg::width_t w,
        input ir_pkg::width_t lo,
        input ir_pkg::width_t hi
    );
        return (w >= lo) && (w <= hi);
    endfunction

    // ******************************
    // event classification
    // ******************************

    // a saturated segment never matches a window.
    assign is_mark  = pulse.valid && !pulse.level && !pulse.saturated;
    assign is_space = pulse.valid && pulse.level && !pulse.saturated;

    assign leader_mark = is_mark &&
        in_win(pulse.width, ir_pkg::LEADER_MARK_MIN, ir_pkg::LEADER_MARK_MAX);
    assign bit_mark_ok = is_mark &&
        in_win(pulse.width, ir_pkg::BIT_MARK_MIN, ir_pkg::BIT_MARK_MAX);
    assign zero_space  = is_space &&
        in_win(pulse.width, ir_pkg::ZERO_SPACE_MIN, ir_pkg::ZERO_SPACE_MAX);
    assign one_space   = is_space &&
        in_win(pulse.width, ir_pkg::ONE_SPACE_MIN, ir_pkg::ONE_SPACE_MAX);
    assign leader_gap  = is_space &&
        in_win(pulse.width, ir_pkg::LEADER_SPACE_MIN, ir_pkg::LEADER_SPACE_MAX);
    assign repeat_gap  = is_space &&
        in_win(pulse.width, ir_pkg::REPEAT_SPACE_MIN, ir_pkg::REPEAT_SPACE_MAX);

    // lsb first, so new bits come in at the top.
    assign shift_next = {one_space, shift_reg[ir_pkg::FRAME_BITS-1:1]};

    assign bit_taken  = (state == ir_pkg::bit_space) && (zero_space || one_space);
    assign last_bit   = bit_cnt == ir_pkg::BIT_CNT_W'(ir_pkg::FRAME_BITS - 1);
    assign inverse_ok = shift_next[31:24] == ~shift_next[23:16];
    assign frame_ok   = bit_taken && last_bit && inverse_ok;
    assign repeat_hit = (state == ir_pkg::leader_space) && repeat_gap;

    // ******************************
    // state machine
    // ******************************

    always_ff @(posedge clk_1us or negedge ir) begin
        if (!ir) begin
            state     <= ir_pkg::idle;
            bit_cnt   <= '0;
            have_last <= 1'b0;
            push      <= 1'b0;
        end else begin
            push <= frame_ok || (repeat_hit && have_last);
            if (frame_ok) begin
                have_last <= 1'b1;
            end
            if (pulse.valid) begin
                if (leader_mark) begin
                    // a fresh leader restarts from any state.
                    state <= ir_pkg::leader_space;
                end else begin
                    case (state)
                        ir_pkg::leader_space: begin
                            if (leader_gap) begin
                                state   <= ir_pkg::bit_mark;
                                bit_cnt <= '0;
                            end else if (repeat_gap) begin
                                state <= ir_pkg::repeat_mark;
                            end else begin
                                state <= ir_pkg::idle;
                            end
                        end
                        ir_pkg::bit_mark: begin
                            state <= bit_mark_ok ? ir_pkg::bit_space : ir_pkg::idle;
                        end
                        ir_pkg::bit_space: begin
                            if (bit_taken) begin
                                bit_cnt <= bit_cnt + 1'b1;
                                state   <= last_bit ? ir_pkg::stop_mark : ir_pkg::bit_mark;
                            end else begin
                                state <= ir_pkg::idle;
                            end
                        end
                        // trailing mark just closes the sequence.
                        default: begin
                            state <= ir_pkg::idle;
                        end
                    endcase
                end
            end
        end
    end

    // ******************************
    // data path
    // ******************************

    always_ff @(posedge clk_1us) begin
        if (bit_taken) begin
            shift_reg <= shift_next;
        end
        if (frame_ok) begin
            last_addr <= shift_next[15:0];
            last_cmd  <= shift_next[23:16];
            push_code <= {1'b0, shift_next[15:0], shift_next[23:16]};
        end else if (repeat_hit) begin
            push_code <= {1'b1, last_addr, last_cmd};
        end
    end

endmodule

//--- tb/nec_tx_tasks.svh
// ******************************
// line shaping
// ******************************

// level 0 is a mark.
task automatic drive_level(input logic level, input int cycles);
    ir_rx <= level;
    repeat (cycles) @(posedge clk_1us);
endtask

task automatic send_leader(input int space_cycles);
    drive_level(1'b0, LEADER_MARK_T);
    drive_level(1'b1, space_cycles);
endtask

// lsb first, a mark before every space.
task automatic send_bits(input logic [31:0] word, input int nbits);
    for (int i = 0; i < nbits; i++) begin
        drive_level(1'b0, BIT_MARK_T);
        drive_level(1'b1, word[i] ? ONE_SPACE_T : ZERO_SPACE_T);
    end
endtask

task automatic send_word(input logic [31:0] word);
    send_leader(LEADER_SPACE_T);
    send_bits(word, 32);
    drive_level(1'b0, BIT_MARK_T);
    drive_level(1'b1, FRAME_GAP_T);
endtask

// ******************************
// frames and scoreboard
// ******************************

// the decoder keeps the last good frame even when the queue drops it.
task automatic send_frame(
    input ir_pkg::ir_addr_t addr,
    input ir_pkg::ir_cmd_t  cmd,
    input logic             queued
);
    send_word({~cmd, cmd, addr});
    sb_have_last = 1'b1;
    sb_addr      = addr;
    sb_cmd       = cmd;
    if (queued) begin
        exp_codes.push_back({1'b0, addr, cmd});
    end
endtask

// one inverse bit flipped, so nothing is expected.
task automatic send_bad_inverse(input ir_pkg::ir_addr_t addr, input ir_pkg::ir_cmd_t cmd);
    send_word({~cmd ^ 8'h01, cmd, addr});
endtask

task automatic send_repeat();
    send_leader(REPEAT_SPACE_T);
    drive_level(1'b0, BIT_MARK_T);
    drive_level(1'b1, FRAME_GAP_T);
    if (sb_have_last) begin
        exp_codes.push_back({1'b1, sb_addr, sb_cmd});
    end
endtask

// no stop mark and no gap, the next leader follows at once.
task automatic send_truncated(
    input ir_pkg::ir_addr_t addr,
    input ir_pkg::ir_cmd_t  cmd,
    input int               nbits
);
    send_leader(LEADER_SPACE_T);
    send_bits({~cmd, cmd, addr}, nbits);
endtask

//--- tb/ir_rx_tb.sv
`timescale 1ns/1ps

module ir_rx_tb;

    localparam int LEADER_MARK_T    = 9000;
    localparam int LEADER_SPACE_T   = 4500;
    localparam int REPEAT_SPACE_T   = 2250;
    localparam int BIT_MARK_T       = 560;
    localparam int ZERO_SPACE_T     = 560;
    localparam int ONE_SPACE_T      = 1690;
    localparam int FRAME_GAP_T      = 4000;
    localparam int TOTAL_FRAMES     = 21;
    localparam int WATCHDOG_CYCLES  = TOTAL_FRAMES * 120000 + 100000;
    localparam int CODE_WAIT_CYCLES = 2000;

    logic             clk_1us;
    logic             ir;
    logic             ir_rx;
    logic             credit_return;
    logic             code_valid;
    ir_pkg::ir_code_t code;
    logic             overrun;

    ir_pkg::ir_code_t exp_codes[$];
    ir_pkg::ir_code_t got_codes[$];
    logic             sb_have_last;
    ir_pkg::ir_addr_t sb_addr;
    ir_pkg::ir_cmd_t  sb_cmd;
    logic             hold_credits;
    int               owed;
    logic [31:0]      lfsr_state;
    int               err_count;
    int               pass_tests;
    int               fail_tests;

    ir_rx_top UUT (
        .clk_1us       (clk_1us),
        .ir            (ir),
        .ir_rx         (ir_rx),
        .credit_return (credit_return),
        .code_valid    (code_valid),
        .code          (code),
        .overrun       (overrun)
    );

    initial begin
        clk_1us = 1'b0;
        forever #20 clk_1us = ~clk_1us;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_1us);
        $display("timeout: the tests did not finish in %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    // ******************************
    // random numbers
    // ******************************

    // taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    `include "nec_tx_tasks.svh"

    // ******************************
    // consumer model and checks
    // ******************************

    // one credit per code, returned as separate pulses.
    always @(posedge clk_1us) begin
        if (!ir) begin
            owed = 0;
        end else if (code_valid) begin
            got_codes.push_back(code);
            owed = owed + 1;
        end
        if (owed > 0 && !hold_credits && !credit_return) begin
            credit_return <= 1'b1;
            owed = owed - 1;
        end else begin
            credit_return <= 1'b0;
        end
    end

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    task automatic compare_codes();
        int waited;
        waited = 0;
        while (got_codes.size() < exp_codes.size() && waited < CODE_WAIT_CYCLES) begin
            @(posedge clk_1us);
            waited++;
        end
        repeat (20) @(posedge clk_1us);
        if (got_codes.size() < exp_codes.size()) begin
            $display("missing codes: expected %0d but received %0d", exp_codes.size(),
                     got_codes.size());
            err_count++;
        end else if (got_codes.size() > exp_codes.size()) begin
            $display("extra codes: expected %0d but received %0d", exp_codes.size(),
                     got_codes.size());
            err_count++;
        end
        for (int i = 0; i < exp_codes.size() && i < got_codes.size(); i++) begin
            check_value($sformatf("code %0d", i), got_codes[i], exp_codes[i]);
        end
        exp_codes.delete();
        got_codes.delete();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            pass_tests++;
            $display("test %s: ok", name);
        end else begin
            fail_tests++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
    endtask

    // ******************************
    // tests
    // ******************************

    task automatic test_repeat();
        int e;
        e = err_count;
        send_repeat();
        send_frame(rand_bits(16), rand_bits(8), 1'b1);
        send_repeat();
        compare_codes();
        finish_test("repeat", e);
    endtask

    task automatic test_valid_frames();
        int e;
        e = err_count;
        for (int i = 0; i < 4; i++) begin
            send_frame(rand_bits(16), rand_bits(8), 1'b1);
        end
        compare_codes();
        finish_test("valid_frames", e);
    endtask

    task automatic test_inverse_error();
        int e;
        e = err_count;
        send_bad_inverse(rand_bits(16), rand_bits(8));
        send_frame(rand_bits(16), rand_bits(8), 1'b1);
        compare_codes();
        finish_test("inverse_error", e);
    endtask

    // the third code waits in the fifo until credits come back.
    task automatic test_back_pressure();
        int e;
        e = err_count;
        hold_credits <= 1'b1;
        for (int i = 0; i < 3; i++) begin
            send_frame(rand_bits(16), rand_bits(8), 1'b1);
        end
        check_value("codes under back-pressure", got_codes.size(),
                    ir_pkg::CONSUMER_CREDITS);
        hold_credits <= 1'b0;
        compare_codes();
        finish_test("back_pressure", e);
    endtask

    task automatic test_overrun();
        int e;
        e = err_count;
        hold_credits <= 1'b1;
        for (int i = 0; i < ir_pkg::QUEUE_DEPTH + ir_pkg::CONSUMER_CREDITS + 1; i++) begin
            send_frame(rand_bits(16), rand_bits(8),
                       i < ir_pkg::QUEUE_DEPTH + ir_pkg::CONSUMER_CREDITS);
            // nothing dropped while the fifo is just full.
            if (i == ir_pkg::QUEUE_DEPTH + ir_pkg::CONSUMER_CREDITS - 1) begin
                check_value("overrun flag with the fifo full", overrun, 1'b0);
            end
        end
        check_value("overrun flag", overrun, 1'b1);
        hold_credits <= 1'b0;
        compare_codes();
        finish_test("overrun", e);
    endtask

    task automatic test_recovery();
        int e;
        e = err_count;
        send_truncated(rand_bits(16), rand_bits(8), 10);
        send_frame(rand_bits(16), rand_bits(8), 1'b1);
        compare_codes();
        finish_test("recovery", e);
    endtask

    initial begin
        ir            = 1'b0;
        ir_rx         = 1'b1;
        credit_return = 1'b0;
        hold_credits  = 1'b0;
        sb_have_last  = 1'b0;
        owed          = 0;
        lfsr_state    = 32'hb92e5c31;
        err_count     = 0;
        pass_tests    = 0;
        fail_tests    = 0;
        repeat (16) @(posedge clk_1us);
        ir <= 1'b1;
        repeat (100) @(posedge clk_1us);
        // must run first, while no frame has been accepted.
        test_repeat();
        test_valid_frames();
        test_inverse_error();
        test_back_pressure();
        test_overrun();
        test_recovery();
        $display("tests passed %0d failed %0d", pass_tests, fail_tests);
        if (err_count == 0 && fail_tests == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
